// ==== dispatch_pkg.sv ====
// widths fixed at RV32; SB_DEPTH must stay a power of two so commit IDs cover every entry
package dispatch_pkg;

    localparam int XLEN = 32;

    // outstanding loads tracked by the scoreboard
    localparam int SB_DEPTH = 4;
    localparam int COMMIT_ID_W = $clog2(SB_DEPTH);

    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W = 4;
    localparam int WMASK_W = XLEN / 8;

    // register data, immediates, operands, addresses
    typedef logic [XLEN-1:0] word_t;

    // x0 is index 0 and never causes a hazard
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // opaque to dispatch, passed to the ALU as is
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    typedef logic [COMMIT_ID_W-1:0] commit_id_t;

    // bit n enables byte n
    typedef logic [WMASK_W-1:0] wmask_t;

    // encoding 2'b11 is unused
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

endpackage

// ==== dispatch_if.sv ====
// request bundles between dispatch units; plain signals, no handshake of their own
`timescale 1ns/1ps

interface alu_req_if;
    import dispatch_pkg::*;

    logic    req;
    alu_op_t op;
    word_t   op1;
    word_t   op2;

    modport src (
        output req,
        output op,
        output op1,
        output op2
    );

    modport dst (
        input req,
        input op,
        input op1,
        input op2
    );

endinterface

interface mem_req_if;
    import dispatch_pkg::*;

    // req, load and store stay low on a misaligned access
    logic   req;
    logic   load;
    logic   store;
    word_t  addr;
    wmask_t wmask;
    word_t  wdata;
    logic   misaligned_load;
    logic   misaligned_store;

    modport src (
        output req,
        output load,
        output store,
        output addr,
        output wmask,
        output wdata,
        output misaligned_load,
        output misaligned_store
    );

    modport dst (
        input req,
        input load,
        input store,
        input addr,
        input wmask,
        input wdata,
        input misaligned_load,
        input misaligned_store
    );

    // hazard unit only needs to see aligned loads
    modport mon (
        input req,
        input load
    );

endinterface

// ==== hazard_unit.sv ====
// no bypass: any pending load blocks its consumers; a commit frees its entry one edge later
`timescale 1ns/1ps

module hazard_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    inst_valid_i,
    input  dispatch_pkg::reg_addr_t rs1_addr_i,
    input  dispatch_pkg::reg_addr_t rs2_addr_i,
    input  logic                    rs1_re_i,
    input  logic                    rs2_re_i,
    input  dispatch_pkg::reg_addr_t rd_addr_i,
    input  logic                    stall_i,
    input  logic                    commit_valid_i,
    input  dispatch_pkg::commit_id_t commit_id_i,
    mem_req_if.mon                  mem,
    output logic                    hazard_stall_o,
    output logic                    issue_o,
    output logic                    pipe_en_o,
    output dispatch_pkg::commit_id_t alloc_id_o
);
    import dispatch_pkg::*;

    logic [SB_DEPTH-1:0] busy_q;
    reg_addr_t           rd_q [SB_DEPTH];
    logic [SB_DEPTH-1:0] rs1_hit;
    logic [SB_DEPTH-1:0] rs2_hit;
    logic                rs1_wait;
    logic                rs2_wait;
    logic                sb_full;
    logic                load_issue;

    // compare sources against every pending load destination
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            rs1_hit[i] = busy_q[i] && (rd_q[i] == rs1_addr_i);
            rs2_hit[i] = busy_q[i] && (rd_q[i] == rs2_addr_i);
        end
    end

    // x0 reads never wait
    assign rs1_wait = rs1_re_i && (rs1_addr_i != '0) && (|rs1_hit);
    assign rs2_wait = rs2_re_i && (rs2_addr_i != '0) && (|rs2_hit);
    assign sb_full  = &busy_q;

    assign hazard_stall_o = inst_valid_i
                          && (rs1_wait || rs2_wait || (mem.req && mem.load && sb_full));

    assign issue_o    = inst_valid_i && !hazard_stall_o && !stall_i;
    assign pipe_en_o  = !stall_i;
    assign load_issue = issue_o && mem.req && mem.load;

    // lowest free entry wins
    always_comb begin
        alloc_id_o = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                alloc_id_o = commit_id_t'(i);
            end
        end
    end

    // allocation is written after the commit, so it wins on a shared index
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (commit_valid_i) begin
                busy_q[commit_id_i] <= 1'b0;
            end
            if (load_issue) begin
                busy_q[alloc_id_o] <= 1'b1;
            end
        end
    end

    // destination only matters while the busy bit is set
    always_ff @(posedge clk) begin
        if (load_issue) begin
            rd_q[alloc_id_o] <= rd_addr_i;
        end
    end

endmodule

// ==== alu_issue.sv ====
// purely combinational; req is not qualified by instruction valid, the pipe register does that
`timescale 1ns/1ps

module alu_issue (
    input  logic                  is_alu_i,
    input  logic                  alu_src_pc_i,
    input  logic                  alu_src_imm_i,
    input  dispatch_pkg::alu_op_t alu_op_i,
    input  dispatch_pkg::word_t   pc_i,
    input  dispatch_pkg::word_t   imm_i,
    input  dispatch_pkg::word_t   rs1_rdata_i,
    input  dispatch_pkg::word_t   rs2_rdata_i,
    alu_req_if.src                alu
);

    assign alu.req = is_alu_i;
    assign alu.op  = alu_op_i;

    // auipc and jal-style ops take the PC as first operand
    assign alu.op1 = alu_src_pc_i ? pc_i : rs1_rdata_i;

    // I-type takes the immediate
    assign alu.op2 = alu_src_imm_i ? imm_i : rs2_rdata_i;

endmodule

// ==== mem_agu.sv ====
// combinational; size encoding 2'b11 yields an empty mask and is never flagged misaligned
`timescale 1ns/1ps

module mem_agu (
    input  logic                    is_load_i,
    input  logic                    is_store_i,
    input  dispatch_pkg::mem_size_e mem_size_i,
    input  dispatch_pkg::word_t     imm_i,
    input  dispatch_pkg::word_t     rs1_rdata_i,
    input  dispatch_pkg::word_t     rs2_rdata_i,
    mem_req_if.src                  mem
);
    import dispatch_pkg::*;

    word_t  addr;
    wmask_t wmask;
    word_t  wdata;
    logic   misaligned;

    assign addr = rs1_rdata_i + imm_i;

    always_comb begin
        case (mem_size_i)
            MEM_BYTE: begin
                wmask      = wmask_t'(4'b0001) << addr[1:0];
                wdata      = {4{rs2_rdata_i[7:0]}};
                misaligned = 1'b0;
            end
            MEM_HALF: begin
                // halves land on byte 0 or byte 2
                wmask      = addr[1] ? 4'b1100 : 4'b0011;
                wdata      = {2{rs2_rdata_i[15:0]}};
                misaligned = addr[0];
            end
            MEM_WORD: begin
                wmask      = 4'b1111;
                wdata      = rs2_rdata_i;
                misaligned = |addr[1:0];
            end
            default: begin
                wmask      = '0;
                wdata      = rs2_rdata_i;
                misaligned = 1'b0;
            end
        endcase
    end

    assign mem.addr  = addr;
    assign mem.wmask = wmask;
    assign mem.wdata = wdata;

    // a misaligned access raises only its flag
    assign mem.req   = (is_load_i || is_store_i) && !misaligned;
    assign mem.load  = is_load_i && !misaligned;
    assign mem.store = is_store_i && !misaligned;

    assign mem.misaligned_load  = is_load_i && misaligned;
    assign mem.misaligned_store = is_store_i && misaligned;

endmodule

// ==== dispatch_pipe.sv ====
// one register stage; holds everything when pipe_en_i is low, bubbles when issue_i is low
`timescale 1ns/1ps

module dispatch_pipe (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     pipe_en_i,
    input  logic                     issue_i,
    input  dispatch_pkg::commit_id_t alloc_id_i,
    input  dispatch_pkg::word_t      pc_i,
    input  dispatch_pkg::reg_addr_t  rd_addr_i,
    input  logic                     rd_we_i,
    alu_req_if.dst                   alu,
    mem_req_if.dst                   mem,
    output logic                     pipe_inst_valid_o,
    output dispatch_pkg::word_t      pipe_pc_o,
    output dispatch_pkg::reg_addr_t  pipe_rd_addr_o,
    output logic                     pipe_rd_we_o,
    output dispatch_pkg::commit_id_t commit_id_o,
    output logic                     req_alu_o,
    output dispatch_pkg::alu_op_t    alu_op_o,
    output dispatch_pkg::word_t      alu_op1_o,
    output dispatch_pkg::word_t      alu_op2_o,
    output logic                     req_mem_o,
    output logic                     mem_load_o,
    output logic                     mem_store_o,
    output dispatch_pkg::word_t      mem_addr_o,
    output dispatch_pkg::wmask_t     mem_wmask_o,
    output dispatch_pkg::word_t      mem_wdata_o,
    output logic                     misaligned_load_o,
    output logic                     misaligned_store_o
);

    // control bits, qualified by issue
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pipe_inst_valid_o  <= 1'b0;
            req_alu_o          <= 1'b0;
            req_mem_o          <= 1'b0;
            mem_load_o         <= 1'b0;
            mem_store_o        <= 1'b0;
            misaligned_load_o  <= 1'b0;
            misaligned_store_o <= 1'b0;
        end else if (pipe_en_i) begin
            pipe_inst_valid_o  <= issue_i;
            req_alu_o          <= issue_i && alu.req;
            req_mem_o          <= issue_i && mem.req;
            mem_load_o         <= issue_i && mem.load;
            mem_store_o        <= issue_i && mem.store;
            misaligned_load_o  <= issue_i && mem.misaligned_load;
            misaligned_store_o <= issue_i && mem.misaligned_store;
        end
    end

    // payload follows the same enable
    always_ff @(posedge clk) begin
        if (pipe_en_i) begin
            pipe_pc_o      <= pc_i;
            pipe_rd_addr_o <= rd_addr_i;
            pipe_rd_we_o   <= rd_we_i;
            // only meaningful alongside mem_load_o
            commit_id_o    <= alloc_id_i;
            alu_op_o       <= alu.op;
            alu_op1_o      <= alu.op1;
            alu_op2_o      <= alu.op2;
            mem_addr_o     <= mem.addr;
            mem_wmask_o    <= mem.wmask;
            mem_wdata_o    <= mem.wdata;
        end
    end

endmodule

// ==== dispatch_top.sv ====
// decoder must hold its inputs while hazard_stall_o or stall_i is high; one commit port only
`timescale 1ns/1ps

module dispatch_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     inst_valid_i,
    input  dispatch_pkg::word_t      pc_i,
    input  dispatch_pkg::word_t      imm_i,
    input  dispatch_pkg::word_t      rs1_rdata_i,
    input  dispatch_pkg::word_t      rs2_rdata_i,
    input  dispatch_pkg::reg_addr_t  rs1_addr_i,
    input  dispatch_pkg::reg_addr_t  rs2_addr_i,
    input  logic                     rs1_re_i,
    input  logic                     rs2_re_i,
    input  dispatch_pkg::reg_addr_t  rd_addr_i,
    input  logic                     rd_we_i,
    input  logic                     is_alu_i,
    input  dispatch_pkg::alu_op_t    alu_op_i,
    input  logic                     alu_src_pc_i,
    input  logic                     alu_src_imm_i,
    input  logic                     is_load_i,
    input  logic                     is_store_i,
    input  dispatch_pkg::mem_size_e  mem_size_i,
    input  logic                     stall_i,
    input  logic                     commit_valid_i,
    input  dispatch_pkg::commit_id_t commit_id_i,
    output logic                     hazard_stall_o,
    output logic                     pipe_inst_valid_o,
    output dispatch_pkg::word_t      pipe_pc_o,
    output dispatch_pkg::reg_addr_t  pipe_rd_addr_o,
    output logic                     pipe_rd_we_o,
    output dispatch_pkg::commit_id_t commit_id_o,
    output logic                     req_alu_o,
    output dispatch_pkg::alu_op_t    alu_op_o,
    output dispatch_pkg::word_t      alu_op1_o,
    output dispatch_pkg::word_t      alu_op2_o,
    output logic                     req_mem_o,
    output logic                     mem_load_o,
    output logic                     mem_store_o,
    output dispatch_pkg::word_t      mem_addr_o,
    output dispatch_pkg::wmask_t     mem_wmask_o,
    output dispatch_pkg::word_t      mem_wdata_o,
    output logic                     misaligned_load_o,
    output logic                     misaligned_store_o
);
    import dispatch_pkg::*;

    logic       issue;
    logic       pipe_en;
    commit_id_t alloc_id;

    alu_req_if alu_req ();
    mem_req_if mem_req ();

    hazard_unit u_hazard_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_re_i      (rs1_re_i),
        .rs2_re_i      (rs2_re_i),
        .rd_addr_i     (rd_addr_i),
        .stall_i       (stall_i),
        .commit_valid_i(commit_valid_i),
        .commit_id_i   (commit_id_i),
        .mem           (mem_req.mon),
        .hazard_stall_o(hazard_stall_o),
        .issue_o       (issue),
        .pipe_en_o     (pipe_en),
        .alloc_id_o    (alloc_id)
    );

    alu_issue u_alu_issue (
        .is_alu_i     (is_alu_i),
        .alu_src_pc_i (alu_src_pc_i),
        .alu_src_imm_i(alu_src_imm_i),
        .alu_op_i     (alu_op_i),
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .rs1_rdata_i  (rs1_rdata_i),
        .rs2_rdata_i  (rs2_rdata_i),
        .alu          (alu_req.src)
    );

    mem_agu u_mem_agu (
        .is_load_i  (is_load_i),
        .is_store_i (is_store_i),
        .mem_size_i (mem_size_i),
        .imm_i      (imm_i),
        .rs1_rdata_i(rs1_rdata_i),
        .rs2_rdata_i(rs2_rdata_i),
        .mem        (mem_req.src)
    );

    dispatch_pipe u_dispatch_pipe (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .pipe_en_i         (pipe_en),
        .issue_i           (issue),
        .alloc_id_i        (alloc_id),
        .pc_i              (pc_i),
        .rd_addr_i         (rd_addr_i),
        .rd_we_i           (rd_we_i),
        .alu               (alu_req.dst),
        .mem               (mem_req.dst),
        .pipe_inst_valid_o (pipe_inst_valid_o),
        .pipe_pc_o         (pipe_pc_o),
        .pipe_rd_addr_o    (pipe_rd_addr_o),
        .pipe_rd_we_o      (pipe_rd_we_o),
        .commit_id_o       (commit_id_o),
        .req_alu_o         (req_alu_o),
        .alu_op_o          (alu_op_o),
        .alu_op1_o         (alu_op1_o),
        .alu_op2_o         (alu_op2_o),
        .req_mem_o         (req_mem_o),
        .mem_load_o        (mem_load_o),
        .mem_store_o       (mem_store_o),
        .mem_addr_o        (mem_addr_o),
        .mem_wmask_o       (mem_wmask_o),
        .mem_wdata_o       (mem_wdata_o),
        .misaligned_load_o (misaligned_load_o),
        .misaligned_store_o(misaligned_store_o)
    );

endmodule

// ==== dispatch_assertions.sv ====
// bound into dispatch_top; loads and stores never arrive together and size 2'b11 is never driven
`timescale 1ns/1ps

module dispatch_assertions (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic                     inst_valid_i,
    input dispatch_pkg::word_t      pc_i,
    input dispatch_pkg::word_t      imm_i,
    input dispatch_pkg::word_t      rs1_rdata_i,
    input dispatch_pkg::word_t      rs2_rdata_i,
    input dispatch_pkg::reg_addr_t  rd_addr_i,
    input logic                     rd_we_i,
    input logic                     is_alu_i,
    input dispatch_pkg::alu_op_t    alu_op_i,
    input logic                     alu_src_pc_i,
    input logic                     alu_src_imm_i,
    input logic                     is_load_i,
    input logic                     is_store_i,
    input dispatch_pkg::mem_size_e  mem_size_i,
    input logic                     stall_i,
    input logic                     hazard_stall_o,
    input logic                     pipe_inst_valid_o,
    input dispatch_pkg::word_t      pipe_pc_o,
    input dispatch_pkg::reg_addr_t  pipe_rd_addr_o,
    input logic                     pipe_rd_we_o,
    input dispatch_pkg::commit_id_t commit_id_o,
    input logic                     req_alu_o,
    input dispatch_pkg::alu_op_t    alu_op_o,
    input dispatch_pkg::word_t      alu_op1_o,
    input dispatch_pkg::word_t      alu_op2_o,
    input logic                     req_mem_o,
    input logic                     mem_load_o,
    input logic                     mem_store_o,
    input dispatch_pkg::word_t      mem_addr_o,
    input dispatch_pkg::wmask_t     mem_wmask_o,
    input dispatch_pkg::word_t      mem_wdata_o,
    input logic                     misaligned_load_o,
    input logic                     misaligned_store_o
);
    import dispatch_pkg::*;

    // number of failed assertions so far
    int error_count = 0;

    logic  accept;
    word_t addr;
    logic  mis;

    assign accept = inst_valid_i && !hazard_stall_o && !stall_i;
    assign addr   = rs1_rdata_i + imm_i;
    assign mis    = (mem_size_i == MEM_HALF && addr[0])
                 || (mem_size_i == MEM_WORD && addr[1:0] != 2'b00);

    // bytes covered by the access, starting at its aligned offset
    function automatic wmask_t expect_mask(mem_size_e size, word_t a);
        int     first;
        int     len;
        wmask_t m;
        m     = '0;
        first = (size == MEM_BYTE) ? int'(a[1:0]) : (size == MEM_HALF) ? 2 * int'(a[1]) : 0;
        len   = (size == MEM_BYTE) ? 1 : (size == MEM_HALF) ? 2 : 4;
        for (int n = 0; n < 4; n++) begin
            m[n] = (n >= first) && (n < first + len);
        end
        return m;
    endfunction

    function automatic word_t expect_wdata(mem_size_e size, word_t d);
        if (size == MEM_BYTE) begin
            return {d[7:0], d[7:0], d[7:0], d[7:0]};
        end else if (size == MEM_HALF) begin
            return {d[15:0], d[15:0]};
        end
        return d;
    endfunction

    reset_out: assert property (@(posedge clk) !rst_n_i |=> !pipe_inst_valid_o && !req_alu_o
        && !req_mem_o && !mem_load_o && !mem_store_o && !misaligned_load_o && !misaligned_store_o)
        else begin error_count++; $error("outputs not cleared by reset"); end

    // one cycle after any reset edge the scoreboard must be empty
    reset_stall: assert property (@(posedge clk) !rst_n_i |=> !hazard_stall_o)
        else begin error_count++; $error("hazard stall raised during or right after reset"); end

    pipe_payload: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept |=> pipe_inst_valid_o && pipe_pc_o == $past(pc_i)
        && pipe_rd_addr_o == $past(rd_addr_i) && pipe_rd_we_o == $past(rd_we_i))
        else begin error_count++; $error("pipe valid, PC or destination wrong"); end

    alu_dispatch: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && is_alu_i |=> pipe_inst_valid_o && req_alu_o && alu_op_o == $past(alu_op_i)
        && alu_op1_o == ($past(alu_src_pc_i) ? $past(pc_i) : $past(rs1_rdata_i))
        && alu_op2_o == ($past(alu_src_imm_i) ? $past(imm_i) : $past(rs2_rdata_i)))
        else begin error_count++; $error("ALU request or operands wrong"); end

    mem_payload: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && (is_load_i || is_store_i) |=> mem_addr_o == $past(addr)
        && mem_wmask_o == expect_mask($past(mem_size_i), $past(addr))
        && mem_wdata_o == expect_wdata($past(mem_size_i), $past(rs2_rdata_i)))
        else begin error_count++; $error("memory address, mask or store data wrong"); end

    load_flags: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && is_load_i |=> mem_load_o == !$past(mis) && req_mem_o == !$past(mis)
        && misaligned_load_o == $past(mis) && !mem_store_o)
        else begin error_count++; $error("load request or misaligned flag wrong"); end

    store_flags: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && is_store_i |=> mem_store_o == !$past(mis) && req_mem_o == !$past(mis)
        && misaligned_store_o == $past(mis) && !mem_load_o)
        else begin error_count++; $error("store request or misaligned flag wrong"); end

    hold_ctrl: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(pipe_inst_valid_o) && $stable(req_alu_o) && $stable(req_mem_o)
        && $stable(mem_load_o) && $stable(mem_store_o) && $stable(misaligned_load_o)
        && $stable(misaligned_store_o) && $stable(commit_id_o))
        else begin error_count++; $error("control outputs changed under stall"); end

    hold_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(pipe_pc_o) && $stable(pipe_rd_addr_o) && $stable(pipe_rd_we_o)
        && $stable(alu_op_o) && $stable(alu_op1_o) && $stable(alu_op2_o)
        && $stable(mem_addr_o) && $stable(mem_wmask_o) && $stable(mem_wdata_o))
        else begin error_count++; $error("payload outputs changed under stall"); end

    bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_stall_o && !stall_i |=> !pipe_inst_valid_o && !req_alu_o && !req_mem_o)
        else begin error_count++; $error("hazard stall did not insert a bubble"); end

endmodule

// ==== tb_dispatch.sv ====
// random stimulus with a scoreboard model; register indices limited to x0..x3 to force hazards
`timescale 1ns/1ps

module tb_dispatch;
    import dispatch_pkg::*;

    localparam int NUM_CYCLES  = 3000;
    localparam int RESET_CYCLES = 8;
    localparam int WATCHDOG_NS = (NUM_CYCLES + RESET_CYCLES + 100) * 4;

    logic clk;
    logic rst_n_i;
    logic inst_valid_i;
    word_t pc_i;
    word_t imm_i;
    word_t rs1_rdata_i;
    word_t rs2_rdata_i;
    reg_addr_t rs1_addr_i;
    reg_addr_t rs2_addr_i;
    logic rs1_re_i;
    logic rs2_re_i;
    reg_addr_t rd_addr_i;
    logic rd_we_i;
    logic is_alu_i;
    alu_op_t alu_op_i;
    logic alu_src_pc_i;
    logic alu_src_imm_i;
    logic is_load_i;
    logic is_store_i;
    mem_size_e mem_size_i;
    logic stall_i;
    logic commit_valid_i;
    commit_id_t commit_id_i;
    logic hazard_stall_o;
    logic pipe_inst_valid_o;
    word_t pipe_pc_o;
    reg_addr_t pipe_rd_addr_o;
    logic pipe_rd_we_o;
    commit_id_t commit_id_o;
    logic req_alu_o;
    alu_op_t alu_op_o;
    word_t alu_op1_o;
    word_t alu_op2_o;
    logic req_mem_o;
    logic mem_load_o;
    logic mem_store_o;
    word_t mem_addr_o;
    wmask_t mem_wmask_o;
    word_t mem_wdata_o;
    logic misaligned_load_o;
    logic misaligned_store_o;

    // model of outstanding loads
    logic       busy_m [SB_DEPTH];
    reg_addr_t  rd_m [SB_DEPTH];
    logic       load_pending;
    commit_id_t expect_id;
    logic       hold_next;
    logic [31:0] rand_state;

    dispatch_top u_dispatch_top (.*);

    bind dispatch_top dispatch_assertions u_dispatch_assertions (.*);

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic logic is_misaligned(mem_size_e size, word_t a);
        return (size == MEM_HALF && a[0]) || (size == MEM_WORD && a[1:0] != 2'b00);
    endfunction

    function automatic logic waits_on_load(logic re, reg_addr_t src);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            hit = hit || (busy_m[i] && rd_m[i] == src);
        end
        return re && src != '0 && hit;
    endfunction

    task automatic stop_with_error(string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        stop_with_error("timeout: the run did not reach its end");
    end

    always @(negedge clk) begin
        if (u_dispatch_top.u_dispatch_assertions.error_count != 0) begin
            stop_with_error("a concurrent assertion failed");
        end
    end

    // hazard prediction and commit IDs, checked mid-cycle when everything is settled
    always @(negedge clk) begin
        logic       full;
        logic       pred;
        commit_id_t free_id;
        logic       aligned_load;
        if (!rst_n_i) begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                busy_m[i] = 1'b0;
                rd_m[i]   = '0;
            end
            load_pending = 1'b0;
            hold_next    = 1'b0;
        end else begin
            full    = 1'b1;
            free_id = '0;
            for (int i = SB_DEPTH - 1; i >= 0; i--) begin
                full = full && busy_m[i];
                if (!busy_m[i]) begin
                    free_id = commit_id_t'(i);
                end
            end
            aligned_load = is_load_i && !is_misaligned(mem_size_i, rs1_rdata_i + imm_i);
            pred = inst_valid_i && (waits_on_load(rs1_re_i, rs1_addr_i)
                || waits_on_load(rs2_re_i, rs2_addr_i) || (aligned_load && full));
            if (hazard_stall_o !== pred) begin
                stop_with_error($sformatf("Fail hazard_stall_o got %h expected %h",
                    hazard_stall_o, pred));
            end
            if (load_pending && (!mem_load_o || commit_id_o !== expect_id)) begin
                stop_with_error($sformatf("Fail commit_id_o got %h expected %h",
                    commit_id_o, expect_id));
            end
            load_pending = inst_valid_i && !pred && !stall_i && aligned_load;
            expect_id    = free_id;
            if (commit_valid_i) begin
                busy_m[commit_id_i] = 1'b0;
            end
            // allocation wins over a commit of the same entry
            if (load_pending) begin
                busy_m[free_id] = 1'b1;
                rd_m[free_id]   = rd_addr_i;
            end
            hold_next = inst_valid_i && (hazard_stall_o || stall_i);
        end
    end

    task automatic drive_cycle();
        logic [31:0] r;
        logic [1:0]  kind;
        r = next_rand();
        stall_i        <= (r[2:0] == 3'd0);
        commit_valid_i <= (r[5:3] < 3'd3);
        commit_id_i    <= r[7:6];
        // decoder keeps a waiting instruction steady
        if (!hold_next) begin
            r    = next_rand();
            kind = r[3:2];
            inst_valid_i  <= r[0] | r[1];
            is_alu_i      <= (kind == 2'd0) || (kind == 2'd3);
            is_load_i     <= (kind == 2'd1);
            is_store_i    <= (kind == 2'd2);
            rs1_addr_i    <= reg_addr_t'(r[5:4]);
            rs2_addr_i    <= reg_addr_t'(r[7:6]);
            rd_addr_i     <= reg_addr_t'(r[9:8]);
            rs1_re_i      <= r[10];
            rs2_re_i      <= r[11];
            rd_we_i       <= r[12];
            alu_src_pc_i  <= r[13];
            alu_src_imm_i <= r[14];
            alu_op_i      <= r[18:15];
            mem_size_i    <= (r[20:19] == 2'd0) ? MEM_BYTE
                           : (r[20:19] == 2'd1) ? MEM_HALF : MEM_WORD;
            imm_i         <= {26'd0, r[26:21]};
            pc_i          <= next_rand() & 32'hffff_fffc;
            rs1_rdata_i   <= next_rand();
            rs2_rdata_i   <= next_rand();
        end
    endtask

    initial begin
        rand_state     = 32'hefe7;
        rst_n_i        = 1'b0;
        // a load reading x1 is offered while reset is held
        inst_valid_i   = 1'b1;
        pc_i           = '0;
        imm_i          = '0;
        rs1_rdata_i    = '0;
        rs2_rdata_i    = '0;
        rs1_addr_i     = reg_addr_t'(1);
        rs2_addr_i     = '0;
        rs1_re_i       = 1'b1;
        rs2_re_i       = 1'b0;
        rd_addr_i      = reg_addr_t'(1);
        rd_we_i        = 1'b1;
        is_alu_i       = 1'b0;
        alu_op_i       = '0;
        alu_src_pc_i   = 1'b0;
        alu_src_imm_i  = 1'b0;
        is_load_i      = 1'b1;
        is_store_i     = 1'b0;
        mem_size_i     = MEM_BYTE;
        stall_i        = 1'b0;
        commit_valid_i = 1'b0;
        commit_id_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            drive_cycle();
        end
        @(negedge clk);
        if (u_dispatch_top.u_dispatch_assertions.error_count != 0) begin
            stop_with_error("concurrent assertion failures were recorded");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
dispatch_pkg.sv
dispatch_if.sv
hazard_unit.sv
alu_issue.sv
mem_agu.sv
dispatch_pipe.sv
dispatch_top.sv
dispatch_assertions.sv
tb_dispatch.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= tb_dispatch
FILELIST ?= sources.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
RUNARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP)
	-./$(OBJDIR)/$(TOP) $(RUNARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "\*\* PASS \*\*" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
